// ==== design/pixel_params.svh ====
`ifndef PIXEL_PARAMS_SVH
`define PIXEL_PARAMS_SVH

// Fragment sideband widths
`define PIX_INDEX_WIDTH         14
`define PIX_SCREEN_POS_WIDTH    11

// Texel memory address
`define PIX_TEX_ADDR_WIDTH      17

// One color channel, four of them per pixel
`define PIX_SUB_PIXEL_WIDTH     8

// Attribute formats
`define PIX_FLOAT_WIDTH         32
`define PIX_FIXED_WIDTH         32

// Fraction bits after conversion
`define PIX_DEPTH_FRAC          16
`define PIX_TEX_FRAC            15
`define PIX_COLOR_FRAC          16

// Texture configuration field widths
`define PIX_LOG2_SIZE_WIDTH     4
`define PIX_TEXENV_WIDTH        2

// Texture combine codes
`define PIX_TEXENV_REPLACE      2'd0
`define PIX_TEXENV_MODULATE     2'd1
`define PIX_TEXENV_ADD          2'd2

`endif

// ==== design/pixel_pkg.sv ====
package pixel_pkg;

`include "pixel_params.svh"

    // Scalar types
    typedef logic [`PIX_FLOAT_WIDTH-1:0]            float_t;
    typedef logic signed [`PIX_FIXED_WIDTH-1:0]     fixed_t;
    typedef logic [`PIX_SUB_PIXEL_WIDTH-1:0]        channel_t;

    // r in the top byte, a in the bottom byte
    typedef logic [4*`PIX_SUB_PIXEL_WIDTH-1:0]      pixel_t;

    typedef logic [`PIX_INDEX_WIDTH-1:0]            index_t;
    typedef logic [`PIX_SCREEN_POS_WIDTH-1:0]       screen_pos_t;
    typedef logic [`PIX_TEX_ADDR_WIDTH-1:0]         tex_addr_t;
    typedef logic [`PIX_TEXENV_WIDTH-1:0]           texenv_func_t;
    typedef logic [`PIX_LOG2_SIZE_WIDTH-1:0]        log2_size_t;

    ////////////////////////////////////////////////////////////////////////////
    // Fragment records
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        index_t         index;
        screen_pos_t    screen_x;
        screen_pos_t    screen_y;
        fixed_t         depth;
        logic           keep;
        logic           last;
    } frag_meta_s;

    // As delivered by the rasterizer
    typedef struct packed {
        index_t         index;
        screen_pos_t    screen_x;
        screen_pos_t    screen_y;
        logic           keep;
        logic           last;
        float_t         depth_z;
        float_t         tex_s;
        float_t         tex_t;
        float_t         color_r;
        float_t         color_g;
        float_t         color_b;
        float_t         color_a;
    } attrib_in_s;

    typedef struct packed {
        frag_meta_s     meta;
        fixed_t         tex_s;
        fixed_t         tex_t;
        pixel_t         primary;
    } conv_frag_s;

    typedef struct packed {
        frag_meta_s     meta;
        pixel_t         color;
    } frag_out_s;

    typedef struct packed {
        logic           enable;
        log2_size_t     width_log2;
        log2_size_t     height_log2;
        texenv_func_t   func;
    } tex_conf_s;

endpackage

// ==== design/float_to_fixed.sv ====
`timescale 1ns/1ps

`include "pixel_params.svh"

module float_to_fixed
#(
    parameter int FRAC_BITS = 16
)
(
    input  logic                aclk,
    input  pixel_pkg::float_t   value,
    output pixel_pkg::fixed_t   result
);

    localparam int MANT_WIDTH  = 23;
    localparam int MAG_WIDTH   = `PIX_FIXED_WIDTH - 1;
    // Largest left shift that keeps the 24 bit mantissa inside the magnitude
    localparam int MAX_LEFT    = MAG_WIDTH - (MANT_WIDTH + 1);
    // Exponent bias plus mantissa position, less the wanted fraction
    localparam int BIAS_SHIFT  = 127 + MANT_WIDTH - FRAC_BITS;
    localparam int SHIFT_WIDTH = 5;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1: decode exponent into a shift
    ////////////////////////////////////////////////////////////////////////////
    logic signed [9:0]          exp_shift;
    logic signed [9:0]          neg_shift;

    logic                       sign_q;
    logic                       zero_q;
    logic                       sat_q;
    logic                       left_q;
    logic [SHIFT_WIDTH-1:0]     shift_q;
    logic [MANT_WIDTH:0]        mant_q;

    always_comb
    begin
        exp_shift = $signed({2'b00, value[30:23]}) - 10'(BIAS_SHIFT);
        neg_shift = -exp_shift;
    end

    always_ff @(posedge aclk)
    begin
        sign_q  <= value[31];
        // Zero and denormals, or everything shifted out on the right
        zero_q  <= (value[30:23] == 8'd0) || (exp_shift <= -(MANT_WIDTH + 1));
        sat_q   <= exp_shift > MAX_LEFT;
        left_q  <= exp_shift >= 0;
        shift_q <= (exp_shift >= 0) ? exp_shift[SHIFT_WIDTH-1:0]
                                    : neg_shift[SHIFT_WIDTH-1:0];
        mant_q  <= {1'b1, value[MANT_WIDTH-1:0]};
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2: shift mantissa, apply sign
    ////////////////////////////////////////////////////////////////////////////
    logic [MAG_WIDTH-1:0]       mag_wide;
    logic [MAG_WIDTH-1:0]       mag;
    pixel_pkg::fixed_t          result_d;

    always_comb
    begin
        mag_wide = {{(MAG_WIDTH - MANT_WIDTH - 1){1'b0}}, mant_q};
        mag = left_q ? (mag_wide << shift_q) : (mag_wide >> shift_q);

        if (zero_q)
            result_d = '0;
        else if (sat_q)
            result_d = sign_q ? {1'b1, {MAG_WIDTH{1'b0}}} : {1'b0, {MAG_WIDTH{1'b1}}};
        else if (sign_q)
            result_d = -$signed({1'b0, mag});   // truncated toward zero
        else
            result_d = $signed({1'b0, mag});
    end

    always_ff @(posedge aclk)
    begin
        result <= result_d;
    end

endmodule

// ==== design/attrib_convert.sv ====
`timescale 1ns/1ps

`include "pixel_params.svh"

module attrib_convert
(
    input  logic                    aclk,
    input  logic                    rst_n,

    input  logic                    attrib_valid,
    input  pixel_pkg::attrib_in_s   attrib,

    output logic                    conv_valid,
    output pixel_pkg::conv_frag_s   conv
);

    localparam int CH_W     = `PIX_SUB_PIXEL_WIDTH;
    localparam int CHANNELS = $bits(pixel_pkg::pixel_t) / CH_W;

    // Clamp a converted color to one channel
    function automatic pixel_pkg::channel_t clamp_channel(input pixel_pkg::fixed_t value);
        pixel_pkg::channel_t chan;
        if (value[`PIX_FIXED_WIDTH-1])
            chan = '0;
        else if (|value[`PIX_FIXED_WIDTH-1:`PIX_COLOR_FRAC])
            chan = '1;
        else
            chan = value[`PIX_COLOR_FRAC-1 -: CH_W];
        return chan;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Float converters
    ////////////////////////////////////////////////////////////////////////////
    pixel_pkg::fixed_t  depth_fix;
    pixel_pkg::fixed_t  s_fix;
    pixel_pkg::fixed_t  t_fix;
    pixel_pkg::float_t  color_flt [CHANNELS];
    pixel_pkg::fixed_t  color_fix [CHANNELS];

    // Index 0 is red, matching the top byte of pixel_t
    assign color_flt[0] = attrib.color_r;
    assign color_flt[1] = attrib.color_g;
    assign color_flt[2] = attrib.color_b;
    assign color_flt[3] = attrib.color_a;

    float_to_fixed #(.FRAC_BITS(`PIX_DEPTH_FRAC)) depth_conv (
        .aclk   (aclk),
        .value  (attrib.depth_z),
        .result (depth_fix)
    );

    float_to_fixed #(.FRAC_BITS(`PIX_TEX_FRAC)) tex_s_conv (
        .aclk   (aclk),
        .value  (attrib.tex_s),
        .result (s_fix)
    );

    float_to_fixed #(.FRAC_BITS(`PIX_TEX_FRAC)) tex_t_conv (
        .aclk   (aclk),
        .value  (attrib.tex_t),
        .result (t_fix)
    );

    for (genvar i = 0; i < CHANNELS; i++)
    begin : g_color
        float_to_fixed #(.FRAC_BITS(`PIX_COLOR_FRAC)) color_conv (
            .aclk   (aclk),
            .value  (color_flt[i]),
            .result (color_fix[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sideband, two cycles to line up with the converters
    ////////////////////////////////////////////////////////////////////////////
    pixel_pkg::frag_meta_s  side_d;
    pixel_pkg::frag_meta_s  side_q1;
    pixel_pkg::frag_meta_s  side_q2;
    logic                   valid_q1;
    logic                   valid_q2;

    always_comb
    begin
        side_d          = '0;
        side_d.index    = attrib.index;
        side_d.screen_x = attrib.screen_x;
        side_d.screen_y = attrib.screen_y;
        side_d.keep     = attrib.keep;
        side_d.last     = attrib.last;
    end

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            valid_q1 <= 1'b0;
            valid_q2 <= 1'b0;
        end
        else
        begin
            valid_q1 <= attrib_valid;
            valid_q2 <= valid_q1;
        end
    end

    always_ff @(posedge aclk)
    begin
        side_q1 <= side_d;
        side_q2 <= side_q1;
    end

    // Depth slots into the sideband once converted
    always_comb
    begin
        conv            = '0;
        conv.meta       = side_q2;
        conv.meta.depth = depth_fix;
        conv.tex_s      = s_fix;
        conv.tex_t      = t_fix;
        for (int i = 0; i < CHANNELS; i++)
            conv.primary[(CHANNELS-1-i)*CH_W +: CH_W] = clamp_channel(color_fix[i]);
    end

    assign conv_valid = valid_q2;

endmodule

// ==== design/texture_unit.sv ====
`timescale 1ns/1ps

`include "pixel_params.svh"

module texture_unit
(
    input  logic                    aclk,
    input  logic                    rst_n,

    input  pixel_pkg::tex_conf_s    tex_conf,

    input  logic                    conv_valid,
    input  pixel_pkg::conv_frag_s   conv,

    // Synchronous read texel memory
    output pixel_pkg::tex_addr_t    texel_addr,
    input  pixel_pkg::pixel_t       texel,

    output logic                    frag_valid,
    output pixel_pkg::frag_out_s    frag
);

    localparam int CH_W     = `PIX_SUB_PIXEL_WIDTH;
    localparam int PROD_W   = 2 * CH_W;
    localparam int CHANNELS = $bits(pixel_pkg::pixel_t) / CH_W;

    // Texture environment for one channel
    function automatic pixel_pkg::channel_t combine_channel(
        input pixel_pkg::texenv_func_t  func,
        input pixel_pkg::channel_t      primary,
        input pixel_pkg::channel_t      texel_ch
    );
        logic [PROD_W-1:0]      product;
        logic [CH_W:0]          sum;
        pixel_pkg::channel_t    chan;
        // +255 rounds the divide by 256 towards one
        product = PROD_W'(primary) * PROD_W'(texel_ch) + PROD_W'(255);
        sum     = (CH_W + 1)'(primary) + (CH_W + 1)'(texel_ch);
        case (func)
            `PIX_TEXENV_REPLACE:  chan = texel_ch;
            `PIX_TEXENV_MODULATE: chan = product[PROD_W-1 -: CH_W];
            `PIX_TEXENV_ADD:      chan = sum[CH_W] ? '1 : sum[CH_W-1:0];
            default:              chan = primary;
        endcase
        return chan;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Nearest texel address, repeat wrap
    ////////////////////////////////////////////////////////////////////////////
    logic [`PIX_FIXED_WIDTH-1:0]    s_scaled;
    logic [`PIX_FIXED_WIDTH-1:0]    t_scaled;
    logic [`PIX_FIXED_WIDTH-1:0]    u;
    logic [`PIX_FIXED_WIDTH-1:0]    v;
    logic [`PIX_FIXED_WIDTH-1:0]    addr_full;

    // Masking the two's complement value also wraps negative coordinates
    always_comb
    begin
        s_scaled  = conv.tex_s >> (`PIX_TEX_FRAC - int'(tex_conf.width_log2));
        t_scaled  = conv.tex_t >> (`PIX_TEX_FRAC - int'(tex_conf.height_log2));
        u         = s_scaled & ((32'd1 << tex_conf.width_log2) - 32'd1);
        v         = t_scaled & ((32'd1 << tex_conf.height_log2) - 32'd1);
        addr_full = (v << tex_conf.width_log2) | u;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline control
    ////////////////////////////////////////////////////////////////////////////
    logic   valid_s1;
    logic   valid_s2;
    logic   valid_s3;

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            valid_s3 <= 1'b0;
        end
        else
        begin
            valid_s1 <= conv_valid;
            valid_s2 <= valid_s1;
            valid_s3 <= valid_s2;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Data path
    ////////////////////////////////////////////////////////////////////////////
    pixel_pkg::tex_addr_t   addr_s1;
    pixel_pkg::frag_meta_s  meta_s1;
    pixel_pkg::frag_meta_s  meta_s2;
    pixel_pkg::pixel_t      primary_s1;
    pixel_pkg::pixel_t      primary_s2;
    pixel_pkg::pixel_t      color_d;
    pixel_pkg::frag_out_s   frag_s3;

    // Cycle 1 address out, cycle 2 texel held in the memory read register
    always_ff @(posedge aclk)
    begin
        addr_s1    <= pixel_pkg::tex_addr_t'(addr_full);
        meta_s1    <= conv.meta;
        primary_s1 <= conv.primary;
        meta_s2    <= meta_s1;
        primary_s2 <= primary_s1;
    end

    // Texel lines up with stage 2
    always_comb
    begin
        if (!tex_conf.enable)
            color_d = primary_s2;
        else
        begin
            for (int i = 0; i < CHANNELS; i++)
                color_d[i*CH_W +: CH_W] = combine_channel(tex_conf.func,
                                                          primary_s2[i*CH_W +: CH_W],
                                                          texel[i*CH_W +: CH_W]);
        end
    end

    always_ff @(posedge aclk)
    begin
        frag_s3.meta  <= meta_s2;
        frag_s3.color <= color_d;
    end

    assign texel_addr = addr_s1;
    assign frag_valid = valid_s3;
    assign frag       = frag_s3;

endmodule

// ==== design/pixel_pipeline.sv ====
`timescale 1ns/1ps

module pixel_pipeline
(
    input  logic                    aclk,
    input  logic                    rst_n,

    // Fragments from the rasterizer, one per cycle at most
    input  logic                    attrib_valid,
    input  pixel_pkg::attrib_in_s   attrib,

    // Static while fragments are in flight
    input  pixel_pkg::tex_conf_s    tex_conf,

    output pixel_pkg::tex_addr_t    texel_addr,
    input  pixel_pkg::pixel_t       texel,

    // Towards the framebuffer, 5 cycles after attrib_valid
    output logic                    frag_valid,
    output pixel_pkg::frag_out_s    frag
);

    ////////////////////////////////////////////////////////////////////////////
    // Float conversion, 2 cycles
    ////////////////////////////////////////////////////////////////////////////
    logic                   conv_valid;
    pixel_pkg::conv_frag_s  conv;

    attrib_convert attrib_convert_i (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .attrib_valid (attrib_valid),
        .attrib       (attrib),
        .conv_valid   (conv_valid),
        .conv         (conv)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Texture unit, 3 cycles
    ////////////////////////////////////////////////////////////////////////////
    texture_unit texture_unit_i (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .tex_conf   (tex_conf),
        .conv_valid (conv_valid),
        .conv       (conv),
        .texel_addr (texel_addr),
        .texel      (texel),
        .frag_valid (frag_valid),
        .frag       (frag)
    );

endmodule

// ==== bench/pixel_clk_gen.sv ====
`timescale 1ns/1ps

module pixel_clk_gen
(
    output logic aclk,
    output logic rst_n
);

    // 20 ns period
    initial
    begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
    end

endmodule

// ==== bench/pixel_checker.sv ====
`timescale 1ns/1ps

module pixel_checker
(
    input  logic                    aclk,
    input  logic                    rst_n,
    input  logic                    frag_valid,
    input  pixel_pkg::frag_out_s    frag
);

    pixel_pkg::frag_out_s   exp_q [$];
    int                     due_q [$];
    int                     cycle_count = 0;
    string                  test_name = "reset";
    int                     test_frags = 0;
    int                     test_errs = 0;
    int                     total_tests = 0;
    int                     total_frags = 0;
    int                     total_errs = 0;

    always @(posedge aclk)
        cycle_count <= cycle_count + 1;

    task add_expected(input pixel_pkg::frag_out_s exp, input int due);
        exp_q.push_back(exp);
        due_q.push_back(due);
    endtask

    function int pending();
        return exp_q.size();
    endfunction

    task start_test(input string name);
        test_name  = name;
        test_frags = 0;
        test_errs  = 0;
    endtask

    task end_test();
        $display("test %s: %0d fragments, %0d errors", test_name, test_frags, test_errs);
        total_tests += 1;
        total_frags += test_frags;
        total_errs  += test_errs;
    endtask

    task summary();
        $display("Tests: %0d, fragments: %0d, errors: %0d",
                 total_tests, total_frags, total_errs);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare on the falling edge, outputs are settled there
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge aclk)
    begin
        pixel_pkg::frag_out_s exp;
        int due;
        if (rst_n === 1'b1 && frag_valid !== 1'b0)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Test %s: output fragment appeared with none expected", test_name);
                test_errs += 1;
            end
            else
            begin
                exp = exp_q.pop_front();
                due = due_q.pop_front();
                test_frags += 1;
                if (frag !== exp)
                begin
                    $display("ERR %s: expected %h actual %h", test_name, exp, frag);
                    test_errs += 1;
                end
                if (cycle_count != due)
                begin
                    $display("Test %s: fragment came out at cycle %0d, due at cycle %0d",
                             test_name, cycle_count, due);
                    test_errs += 1;
                end
            end
        end
    end

endmodule

// ==== bench/pixel_assert.sv ====
`timescale 1ns/1ps

module pixel_assert
(
    input  logic                    aclk,
    input  logic                    rst_n,
    input  logic                    attrib_valid,
    input  logic                    frag_valid,
    input  pixel_pkg::tex_addr_t    texel_addr
);

    // Failed assertion count
    int unsigned fail_count = 0;

    // Reset clears the output valid one edge later
    a_reset_quiet: assert property (@(posedge aclk) !rst_n |=> !frag_valid)
        else
        begin
            $error("frag_valid high after reset");
            fail_count++;
        end

    // Only once five edges out of reset, so the valid history is all known
    a_latency: assert property (@(posedge aclk) disable iff (!rst_n)
                                $past(rst_n, 5) |-> frag_valid == $past(attrib_valid, 5))
        else
        begin
            $error("frag_valid does not follow attrib_valid by 5 cycles");
            fail_count++;
        end

    // Address register holds the fragment taken 3 edges back
    a_addr_known: assert property (@(posedge aclk) disable iff (!rst_n)
                                   $past(attrib_valid, 3) |-> !$isunknown(texel_addr))
        else
        begin
            $error("texel_addr unknown for a fragment in flight");
            fail_count++;
        end

endmodule

bind pixel_pipeline pixel_assert pixel_assert_i (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .attrib_valid (attrib_valid),
    .frag_valid   (frag_valid),
    .texel_addr   (texel_addr)
);

// ==== bench/pixel_tb.sv ====
`timescale 1ns/1ps

`include "pixel_params.svh"

module pixel_tb;

    localparam int TOTAL_FRAGS = 73;
    localparam int MAX_GAP     = 3;
    localparam int NUM_FLOATS  = 12;

    logic                   aclk;
    logic                   rst_n;
    logic                   attrib_valid;
    pixel_pkg::attrib_in_s  attrib;
    pixel_pkg::tex_conf_s   tex_conf;
    pixel_pkg::tex_addr_t   texel_addr;
    pixel_pkg::pixel_t      texel = '0;
    logic                   frag_valid;
    pixel_pkg::frag_out_s   frag;

    logic [31:0]            lfsr = 32'ha80e;
    pixel_pkg::float_t      float_tab [NUM_FLOATS];
    pixel_pkg::pixel_t      tex_mem [2**`PIX_TEX_ADDR_WIDTH];

    pixel_clk_gen clk_gen_i (.aclk(aclk), .rst_n(rst_n));

    pixel_pipeline pixel_pipeline_i (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .attrib_valid (attrib_valid),
        .attrib       (attrib),
        .tex_conf     (tex_conf),
        .texel_addr   (texel_addr),
        .texel        (texel),
        .frag_valid   (frag_valid),
        .frag         (frag)
    );

    pixel_checker checker_i (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .frag_valid (frag_valid),
        .frag       (frag)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Texel memory model, synchronous read
    ////////////////////////////////////////////////////////////////////////////
    function automatic pixel_pkg::pixel_t texel_pattern(input pixel_pkg::tex_addr_t a);
        return {a[7:0] ^ {7'd0, a[16]}, a[15:8] ^ 8'h3c, a[7:0] + a[15:8], ~a[7:0]};
    endfunction

    always @(posedge aclk)
        texel <= tex_mem[texel_addr];

    ////////////////////////////////////////////////////////////////////////////
    // Random source
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // Taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task pick_float(output pixel_pkg::float_t f);
        logic [31:0] r;
        take_bits(4, r);
        f = float_tab[r % NUM_FLOATS];
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic pixel_pkg::fixed_t to_fixed(input pixel_pkg::float_t f, input int frac);
        real mag;
        if (f[30:23] == 8'd0)
            return '0;
        mag = (1.0 + real'(f[22:0]) / 8388608.0) * (2.0 ** (real'(f[30:23]) - 127.0))
              * (2.0 ** frac);
        if (mag >= 2147483648.0)
            return f[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        return f[31] ? -$rtoi(mag) : $rtoi(mag);
    endfunction

    function automatic pixel_pkg::channel_t clamp(input pixel_pkg::fixed_t v);
        if (v < 0)
            return 8'd0;
        if (v[31:16] != 0)
            return 8'd255;
        return v[15:8];
    endfunction

    function automatic int wrap_coord(input pixel_pkg::fixed_t c, input int log2);
        return (c >>> (`PIX_TEX_FRAC - log2)) & ((1 << log2) - 1);
    endfunction

    function automatic pixel_pkg::frag_out_s expected_frag(input pixel_pkg::attrib_in_s a,
                                                           input pixel_pkg::tex_conf_s c);
        pixel_pkg::frag_out_s   e;
        pixel_pkg::pixel_t      prim;
        pixel_pkg::pixel_t      tx;
        int                     u;
        int                     v;
        int                     p;
        int                     t;
        e.meta.index    = a.index;
        e.meta.screen_x = a.screen_x;
        e.meta.screen_y = a.screen_y;
        e.meta.keep     = a.keep;
        e.meta.last     = a.last;
        e.meta.depth    = to_fixed(a.depth_z, `PIX_DEPTH_FRAC);
        prim = {clamp(to_fixed(a.color_r, 16)), clamp(to_fixed(a.color_g, 16)),
                clamp(to_fixed(a.color_b, 16)), clamp(to_fixed(a.color_a, 16))};
        u  = wrap_coord(to_fixed(a.tex_s, `PIX_TEX_FRAC), c.width_log2);
        v  = wrap_coord(to_fixed(a.tex_t, `PIX_TEX_FRAC), c.height_log2);
        tx = texel_pattern(pixel_pkg::tex_addr_t'((v << c.width_log2) | u));
        e.color = prim;
        if (c.enable)
        begin
            for (int i = 0; i < 4; i++)
            begin
                p = prim[i*8 +: 8];
                t = tx[i*8 +: 8];
                case (c.func)
                    `PIX_TEXENV_REPLACE:  e.color[i*8 +: 8] = t;
                    `PIX_TEXENV_MODULATE: e.color[i*8 +: 8] = (p * t + 255) >> 8;
                    `PIX_TEXENV_ADD:      e.color[i*8 +: 8] = (p + t > 255) ? 255 : p + t;
                    default:              e.color[i*8 +: 8] = p;
                endcase
            end
        end
        return e;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////
    task send_frag(input pixel_pkg::attrib_in_s a);
        @(negedge aclk);
        attrib_valid = 1'b1;
        attrib       = a;
        // Taken on the next edge, frag_valid set on the fifth edge from here
        checker_i.add_expected(expected_frag(a, tex_conf), checker_i.cycle_count + 5);
    endtask

    task idle(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(negedge aclk);
            attrib_valid = 1'b0;
        end
    endtask

    task drain();
        idle(1);
        while (checker_i.pending() > 0)
            idle(1);
        idle(2);
        checker_i.end_test();
    endtask

    task random_frag(output pixel_pkg::attrib_in_s a);
        logic [31:0] r;
        take_bits(14, r);
        a.index = r[13:0];
        take_bits(11, r);
        a.screen_x = r[10:0];
        take_bits(11, r);
        a.screen_y = r[10:0];
        take_bits(2, r);
        a.keep = r[1];
        a.last = r[0];
        pick_float(a.depth_z);
        pick_float(a.tex_s);
        pick_float(a.tex_t);
        pick_float(a.color_r);
        pick_float(a.color_g);
        pick_float(a.color_b);
        pick_float(a.color_a);
    endtask

    // Watchdog sized for worst case gaps plus drain
    initial
    begin
        #((TOTAL_FRAGS * (MAX_GAP + 1) + 50) * 20ns);
        $display("Timeout: the pipeline did not deliver all fragments in time");
        $display("Finished with errors");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        pixel_pkg::attrib_in_s  a;
        pixel_pkg::float_t      colors [5];
        int                     wrap_idx [8];
        logic [31:0]            r;

        // 0.0, 0.5, 1.0, 1.5, -0.25, 0.75, 2.25, -1.375, 0.3, 100.5, -0.6, 3.1
        float_tab = '{32'h0000_0000, 32'h3f00_0000, 32'h3f80_0000, 32'h3fc0_0000,
                      32'hbe80_0000, 32'h3f40_0000, 32'h4010_0000, 32'hbfb0_0000,
                      32'h3e99_999a, 32'h42c9_0000, 32'hbf19_999a, 32'h4046_6666};
        for (int i = 0; i < 2**`PIX_TEX_ADDR_WIDTH; i++)
            tex_mem[i] = texel_pattern(pixel_pkg::tex_addr_t'(i));
        attrib_valid = 1'b0;
        attrib       = '0;
        tex_conf     = '{enable: 1'b0, width_log2: 4'd4, height_log2: 4'd3,
                         func: `PIX_TEXENV_REPLACE};
        @(posedge rst_n);

        // 0.0, 0.5, 1.0, 1.5, -0.25
        checker_i.start_test("color_convert");
        colors = '{32'h0000_0000, 32'h3f00_0000, 32'h3f80_0000, 32'h3fc0_0000,
                   32'hbe80_0000};
        for (int i = 0; i < 5; i++)
        begin
            a = '0;
            a.color_r = colors[i];
            a.color_g = colors[i];
            a.color_b = colors[i];
            a.color_a = colors[i];
            send_frag(a);
        end
        drain();

        checker_i.start_test("sideband_depth");
        for (int i = 0; i < 8; i++)
        begin
            random_frag(a);
            send_frag(a);
        end
        drain();

        checker_i.start_test("address_wrap");
        tex_conf.enable = 1'b1;
        // s and t past both ends of the texture, paired in opposite order
        wrap_idx = '{3, 4, 6, 7, 9, 10, 11, 5};
        for (int i = 0; i < 8; i++)
        begin
            random_frag(a);
            a.tex_s = float_tab[wrap_idx[i]];
            a.tex_t = float_tab[wrap_idx[7 - i]];
            send_frag(a);
        end
        drain();

        for (int f = 0; f < 3; f++)
        begin
            checker_i.start_test($sformatf("combine_%0d", f));
            tex_conf.func = pixel_pkg::texenv_func_t'(f);
            idle(1);
            for (int i = 0; i < 4; i++)
            begin
                random_frag(a);
                // Full alpha so that add saturates
                if (i == 0)
                    a.color_a = float_tab[2];
                send_frag(a);
            end
            drain();
        end
        checker_i.start_test("stream");
        take_bits(2, r);
        tex_conf.func = (r[1:0] == 2'd3) ? `PIX_TEXENV_ADD : pixel_pkg::texenv_func_t'(r[1:0]);
        idle(1);
        for (int i = 0; i < 40; i++)
        begin
            random_frag(a);
            a.last = (i == 39);
            send_frag(a);
            take_bits(2, r);
            if (r[1:0] != 0)
                idle(r[1:0]);
        end
        drain();

        checker_i.summary();
        if (checker_i.total_errs == 0 && pixel_pipeline_i.pixel_assert_i.fail_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+design
design/pixel_pkg.sv
design/float_to_fixed.sv
design/attrib_convert.sv
design/texture_unit.sv
design/pixel_pipeline.sv
bench/pixel_clk_gen.sv
bench/pixel_checker.sv
bench/pixel_assert.sv
bench/pixel_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the pixel pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module pixel_tb -f files.f -o Vpixel_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vpixel_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi

if ! grep -q "Finished with no errors" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
